/* rtl/mem_stage_defs.svh */
`ifndef MEM_STAGE_DEFS_SVH
`define MEM_STAGE_DEFS_SVH

// integer register file data and address widths.
`define REG_W 32
`define REG_ADDR_W 5

// csr file address width.
`define CSR_ADDR_W 12

// byte address width of the data bus.
`define MEM_ADDR_W 32

// one byte enable per byte lane of a word.
`define BE_W (`REG_W / 8)

// the RAM is word addressed, so the two low byte address bits drop out.
`define WORD_ADDR_W (`MEM_ADDR_W - 2)

// number of words in the data RAM.
`define RAM_WORDS 256

`endif

/* rtl/mem_pkg.sv */
`default_nettype none

`include "mem_stage_defs.svh"

package mem_pkg;

    // mem_none must stay at zero so that a cleared payload carries no access.
    typedef enum logic [3:0] {
        mem_none = 4'd0,
        mem_lb   = 4'd1,
        mem_lh   = 4'd2,
        mem_lw   = 4'd3,
        mem_lbu  = 4'd4,
        mem_lhu  = 4'd5,
        mem_sb   = 4'd6,
        mem_sh   = 4'd7,
        mem_sw   = 4'd8
    } mem_op_e;

    typedef struct packed {
        logic                    en;    // request valid for this cycle.
        logic                    we;    // write when set, read otherwise.
        logic [`BE_W-1:0]        be;
        logic [`WORD_ADDR_W-1:0] addr;  // word address, not byte address.
        logic [`REG_W-1:0]       wdata;
    } ram_req_t;

endpackage

`default_nettype wire

/* rtl/pipe_pkg.sv */
`default_nettype none

`include "mem_stage_defs.svh"

package pipe_pkg;

    // payload handed from EX into the LS stage.
    typedef struct packed {
        logic                   rd_we;
        logic [`REG_ADDR_W-1:0] rd_addr;
        logic [`REG_W-1:0]      rd_data;    // alu result, or the store data for stores.
        logic [`MEM_ADDR_W-1:0] mem_addr;
        mem_pkg::mem_op_e       mem_op;
        logic                   csr_we;
        logic [`CSR_ADDR_W-1:0] csr_waddr;
        logic [`REG_W-1:0]      csr_wdata;
    } ex_ls_t;

    // payload held between LS and WB while the RAM read completes.
    typedef struct packed {
        logic                   rd_we;
        logic [`REG_ADDR_W-1:0] rd_addr;
        logic [`REG_W-1:0]      rd_data;
        mem_pkg::mem_op_e       mem_op;
        logic [1:0]             offset;     // byte offset within the word, for load lane select.
        logic                   csr_we;
        logic [`CSR_ADDR_W-1:0] csr_waddr;
        logic [`REG_W-1:0]      csr_wdata;
    } ls_wb_t;

    // register file and csr write requests presented to writeback.
    typedef struct packed {
        logic                   rd_we;
        logic [`REG_ADDR_W-1:0] rd_addr;
        logic [`REG_W-1:0]      rd_wdata;
        logic                   csr_we;
        logic [`CSR_ADDR_W-1:0] csr_waddr;
        logic [`REG_W-1:0]      csr_wdata;
    } wb_t;

endpackage

`default_nettype wire

/* rtl/pipe_reg.sv */
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire           clk,
    input  wire           reset_i,
    input  wire           load_i,
    input  wire           clear_i,
    input  wire payload_t d_i,
    output payload_t      q_o
);

    // clear wins over load, so a flush drops the item even when the stage advances.
    always_ff @(posedge clk) begin
        if (reset_i || clear_i) begin
            q_o <= '0;  // an all-zero payload has every enable off and the op set to none.
        end else if (load_i) begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

/* rtl/data_ram.sv */
`default_nettype none

`include "mem_stage_defs.svh"

module data_ram #(
    parameter int DEPTH = `RAM_WORDS
) (
    input  wire                    clk,
    input  wire mem_pkg::ram_req_t req_i,
    output logic [`REG_W-1:0]      rdata_o
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [`REG_W-1:0] mem [DEPTH];
    logic [IDX_W-1:0]  idx;

    assign idx = req_i.addr[IDX_W-1:0];  // upper word address bits alias onto the array.

    // rdata_o only moves on an enabled read, so a stalled load sees stable data.
    always_ff @(posedge clk) begin
        if (req_i.en) begin
            if (req_i.we) begin
                for (int b = 0; b < `BE_W; b++) begin
                    if (req_i.be[b]) begin
                        mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                    end
                end
            end else begin
                rdata_o <= mem[idx];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/lsu.sv */
`default_nettype none

`include "mem_stage_defs.svh"

module lsu (
    input  wire                    clk,
    input  wire                    reset_i,
    input  wire pipe_pkg::ex_ls_t  ls_i,
    input  wire                    stall_ls_i,
    input  wire                    stall_wb_i,
    input  wire                    flush_wb_i,
    output mem_pkg::ram_req_t      ram_req_o,
    input  wire [`REG_W-1:0]       ram_rdata_i,
    output pipe_pkg::wb_t          wb_o,
    output logic                   misalign_o
);

    logic             is_load;
    logic             is_store;
    logic [1:0]       size;     // 0 byte, 1 halfword, 2 word.
    logic [1:0]       offset;
    logic             misalign;
    logic             ls_wb_load;
    logic             ls_wb_clear;
    pipe_pkg::ls_wb_t ls_wb_d;
    pipe_pkg::ls_wb_t ls_wb_q;
    logic [7:0]       ld_byte;
    logic [15:0]      ld_half;
    logic [`REG_W-1:0] rd_wdata;

    assign offset = ls_i.mem_addr[1:0];

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        size     = 2'd0;
        case (ls_i.mem_op)
            mem_pkg::mem_lb, mem_pkg::mem_lbu: begin
                is_load = 1'b1;
            end
            mem_pkg::mem_lh, mem_pkg::mem_lhu: begin
                is_load = 1'b1;
                size    = 2'd1;
            end
            mem_pkg::mem_lw: begin
                is_load = 1'b1;
                size    = 2'd2;
            end
            mem_pkg::mem_sb: begin
                is_store = 1'b1;
            end
            mem_pkg::mem_sh: begin
                is_store = 1'b1;
                size     = 2'd1;
            end
            mem_pkg::mem_sw: begin
                is_store = 1'b1;
                size     = 2'd2;
            end
            default: ;
        endcase
    end

    assign misalign = (is_load || is_store) &&
                      ((size == 2'd1 && offset[0]) || (size == 2'd2 && offset != 2'd0));
    assign misalign_o = misalign;

    // the request is dropped for a misaligned access and while LS is held.
    always_comb begin
        ram_req_o.en   = (is_load || is_store) && !misalign && !stall_ls_i;
        ram_req_o.we   = is_store;
        ram_req_o.addr = ls_i.mem_addr[`MEM_ADDR_W-1:2];
        case (size)
            2'd0: begin
                ram_req_o.be    = `BE_W'(4'b0001 << offset);
                ram_req_o.wdata = {4{ls_i.rd_data[7:0]}};
            end
            2'd1: begin
                ram_req_o.be    = offset[1] ? 4'b1100 : 4'b0011;
                ram_req_o.wdata = {2{ls_i.rd_data[15:0]}};
            end
            default: begin
                ram_req_o.be    = 4'b1111;
                ram_req_o.wdata = ls_i.rd_data;
            end
        endcase
    end

    always_comb begin
        ls_wb_d.rd_we     = ls_i.rd_we && !is_store && !misalign;  // stores never write rd.
        ls_wb_d.rd_addr   = ls_i.rd_addr;
        ls_wb_d.rd_data   = ls_i.rd_data;
        ls_wb_d.mem_op    = ls_i.mem_op;
        ls_wb_d.offset    = offset;
        ls_wb_d.csr_we    = ls_i.csr_we;
        ls_wb_d.csr_waddr = ls_i.csr_waddr;
        ls_wb_d.csr_wdata = ls_i.csr_wdata;
    end

    // a bubble goes into WB when LS holds but WB keeps running.
    assign ls_wb_clear = (stall_ls_i && !stall_wb_i) || flush_wb_i;
    assign ls_wb_load  = !stall_ls_i;

    pipe_reg #(
        .payload_t(pipe_pkg::ls_wb_t)
    ) u_ls_wb (
        .clk    (clk),
        .reset_i(reset_i),
        .load_i (ls_wb_load),
        .clear_i(ls_wb_clear),
        .d_i    (ls_wb_d),
        .q_o    (ls_wb_q)
    );

    assign ld_byte = ram_rdata_i[8*ls_wb_q.offset +: 8];
    assign ld_half = ls_wb_q.offset[1] ? ram_rdata_i[31:16] : ram_rdata_i[15:0];

    always_comb begin
        case (ls_wb_q.mem_op)
            mem_pkg::mem_lb:  rd_wdata = {{(`REG_W-8){ld_byte[7]}}, ld_byte};
            mem_pkg::mem_lbu: rd_wdata = {{(`REG_W-8){1'b0}}, ld_byte};
            mem_pkg::mem_lh:  rd_wdata = {{(`REG_W-16){ld_half[15]}}, ld_half};
            mem_pkg::mem_lhu: rd_wdata = {{(`REG_W-16){1'b0}}, ld_half};
            mem_pkg::mem_lw:  rd_wdata = ram_rdata_i;
            default:          rd_wdata = ls_wb_q.rd_data;  // alu result passes through.
        endcase
    end

    always_comb begin
        wb_o.rd_we     = ls_wb_q.rd_we;
        wb_o.rd_addr   = ls_wb_q.rd_addr;
        wb_o.rd_wdata  = rd_wdata;
        wb_o.csr_we    = ls_wb_q.csr_we;
        wb_o.csr_waddr = ls_wb_q.csr_waddr;
        wb_o.csr_wdata = ls_wb_q.csr_wdata;
    end

endmodule

`default_nettype wire

/* rtl/mem_stage.sv */
`default_nettype none

`include "mem_stage_defs.svh"

module mem_stage (
    input  wire                   clk,
    input  wire                   reset_i,
    input  wire pipe_pkg::ex_ls_t ex_i,
    input  wire [5:0]             stall_i,
    input  wire [3:0]             flush_i,
    output pipe_pkg::wb_t         wb_o,
    output logic                  misalign_o
);

    logic              ex_ls_load;
    logic              ex_ls_clear;
    pipe_pkg::ex_ls_t  ex_ls_q;
    mem_pkg::ram_req_t ram_req;
    logic [`REG_W-1:0] ram_rdata;

    // stall bit 3 is EX, bit 4 is LS, bit 5 is WB.
    // EX held while LS runs leaves a bubble in LS.
    assign ex_ls_clear = (stall_i[3] && !stall_i[4]) || flush_i[2];
    assign ex_ls_load  = !stall_i[3];

    pipe_reg #(
        .payload_t(pipe_pkg::ex_ls_t)
    ) u_ex_ls (
        .clk    (clk),
        .reset_i(reset_i),
        .load_i (ex_ls_load),
        .clear_i(ex_ls_clear),
        .d_i    (ex_i),
        .q_o    (ex_ls_q)
    );

    lsu u_lsu (
        .clk        (clk),
        .reset_i    (reset_i),
        .ls_i       (ex_ls_q),
        .stall_ls_i (stall_i[4]),
        .stall_wb_i (stall_i[5]),
        .flush_wb_i (flush_i[3]),
        .ram_req_o  (ram_req),
        .ram_rdata_i(ram_rdata),
        .wb_o       (wb_o),
        .misalign_o (misalign_o)
    );

    data_ram #(
        .DEPTH(`RAM_WORDS)
    ) u_data_ram (
        .clk    (clk),
        .req_i  (ram_req),
        .rdata_o(ram_rdata)
    );

endmodule

`default_nettype wire

/* verif/mem_stage_sva.sv */
`default_nettype none

module mem_stage_sva (
    input wire                    clk,
    input wire                    reset_i,
    input wire [3:0]              flush_i,
    input wire pipe_pkg::wb_t     wb_o,
    input wire                    misalign_o,
    input wire mem_pkg::ram_req_t ram_req_i
);

    // a misaligned access never reaches the RAM as a write.
    no_misaligned_write: assert property (@(posedge clk) disable iff (reset_i)
        misalign_o |-> !(ram_req_i.en && ram_req_i.we))
        else $error("RAM write issued while misalign_o is high");

    flush_empties_wb: assert property (@(posedge clk) disable iff (reset_i)
        flush_i[3] |=> !wb_o.rd_we && !wb_o.csr_we)
        else $error("writeback enabled in the cycle after an LS/WB flush");

    // every reset edge leaves both registers empty.
    quiet_in_reset: assert property (@(posedge clk)
        reset_i |=> !wb_o.rd_we && !wb_o.csr_we && !misalign_o && !ram_req_i.en)
        else $error("enable active while reset is applied");

endmodule

bind mem_stage mem_stage_sva u_mem_stage_sva (
    .clk       (clk),
    .reset_i   (reset_i),
    .flush_i   (flush_i),
    .wb_o      (wb_o),
    .misalign_o(misalign_o),
    .ram_req_i (ram_req)
);

`default_nettype wire

/* verif/mem_stage_tb.sv */
`default_nettype none

`include "mem_stage_defs.svh"

module mem_stage_tb;

    localparam int MAX_LINES   = 64;
    localparam int FIELDS      = 11;
    localparam int BYTE_IDX_W  = $clog2(4 * `RAM_WORDS);
    localparam int DRAIN_LIMIT = 8;

    logic             clk;
    logic             reset_i;
    pipe_pkg::ex_ls_t ex_i;
    logic [5:0]       stall_i;
    logic [3:0]       flush_i;
    pipe_pkg::wb_t    wb_o;
    logic             misalign_o;

    logic [31:0]      test_words [MAX_LINES * FIELDS];
    logic [7:0]       mem_model [2**BYTE_IDX_W];
    pipe_pkg::ex_ls_t exp_ls;  // item expected in the LS stage.
    pipe_pkg::wb_t    exp_wb;  // writeback expected from the LS/WB register.

    mem_stage UUT (
        .clk       (clk),
        .reset_i   (reset_i),
        .ex_i      (ex_i),
        .stall_i   (stall_i),
        .flush_i   (flush_i),
        .wb_o      (wb_o),
        .misalign_o(misalign_o)
    );

    always #10 clk = ~clk;

    task automatic stop_failed(string reason);
        $display("Simulation FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic report_fail(string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        stop_failed("stopped at the first failed check");
    endtask

    function automatic logic is_misaligned(mem_pkg::mem_op_e op, logic [31:0] addr);
        case (op)
            mem_pkg::mem_lh, mem_pkg::mem_lhu, mem_pkg::mem_sh: return addr[0];
            mem_pkg::mem_lw, mem_pkg::mem_sw: return addr[1:0] != 2'd0;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] load_value(mem_pkg::mem_op_e op, logic [31:0] addr);
        logic [BYTE_IDX_W-1:0] a;
        logic [7:0]            b;
        logic [15:0]           h;
        logic [31:0]           w;
        a = addr[BYTE_IDX_W-1:0];
        b = mem_model[a];
        h = {mem_model[{a[BYTE_IDX_W-1:1], 1'b1}], mem_model[{a[BYTE_IDX_W-1:1], 1'b0}]};
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = mem_model[{a[BYTE_IDX_W-1:2], 2'(i)}];  // little endian.
        end
        case (op)
            mem_pkg::mem_lb:  return {{24{b[7]}}, b};
            mem_pkg::mem_lbu: return {24'd0, b};
            mem_pkg::mem_lh:  return {{16{h[15]}}, h};
            mem_pkg::mem_lhu: return {16'd0, h};
            default:          return w;
        endcase
    endfunction

    task automatic apply_store(pipe_pkg::ex_ls_t it);
        logic [BYTE_IDX_W-1:0] a;
        a = it.mem_addr[BYTE_IDX_W-1:0];
        if (!is_misaligned(it.mem_op, it.mem_addr)) begin
            case (it.mem_op)
                mem_pkg::mem_sb: mem_model[a] = it.rd_data[7:0];
                mem_pkg::mem_sh: begin
                    mem_model[{a[BYTE_IDX_W-1:1], 1'b0}] = it.rd_data[7:0];
                    mem_model[{a[BYTE_IDX_W-1:1], 1'b1}] = it.rd_data[15:8];
                end
                mem_pkg::mem_sw: begin
                    for (int i = 0; i < 4; i++) begin
                        mem_model[{a[BYTE_IDX_W-1:2], 2'(i)}] = it.rd_data[8*i +: 8];
                    end
                end
                default: ;
            endcase
        end
    endtask

    function automatic pipe_pkg::wb_t retire(pipe_pkg::ex_ls_t it);
        pipe_pkg::wb_t r;
        logic          store;
        logic          load;
        store = it.mem_op inside {mem_pkg::mem_sb, mem_pkg::mem_sh, mem_pkg::mem_sw};
        load  = it.mem_op inside {mem_pkg::mem_lb, mem_pkg::mem_lh, mem_pkg::mem_lw,
                                  mem_pkg::mem_lbu, mem_pkg::mem_lhu};
        r.rd_we     = it.rd_we && !store && !is_misaligned(it.mem_op, it.mem_addr);
        r.rd_addr   = it.rd_addr;
        r.rd_wdata  = load ? load_value(it.mem_op, it.mem_addr) : it.rd_data;
        r.csr_we    = it.csr_we;
        r.csr_waddr = it.csr_waddr;
        r.csr_wdata = it.csr_wdata;
        return r;
    endfunction

    // one clock edge of the two stage model.
    task automatic advance_model(pipe_pkg::ex_ls_t ex, logic [5:0] stall, logic [3:0] flush);
        if (flush[3] || (stall[4] && !stall[5])) begin
            exp_wb = '0;
        end else if (!stall[4]) begin
            exp_wb = retire(exp_ls);
        end
        if (!stall[4]) begin
            apply_store(exp_ls);  // the RAM write is issued in LS, ahead of any WB flush.
        end
        if (flush[2] || (stall[3] && !stall[4])) begin
            exp_ls = '0;
        end else if (!stall[3]) begin
            exp_ls = ex;
        end
    endtask

    task automatic check_outputs();
        assert (wb_o.rd_we == exp_wb.rd_we && wb_o.csr_we == exp_wb.csr_we) else
            report_fail($sformatf("rd_we %0b csr_we %0b, expected %0b %0b",
                        wb_o.rd_we, wb_o.csr_we, exp_wb.rd_we, exp_wb.csr_we));
        if (exp_wb.rd_we) begin
            assert (wb_o.rd_addr == exp_wb.rd_addr && wb_o.rd_wdata == exp_wb.rd_wdata) else
                report_fail($sformatf("x%0d = %h, expected x%0d = %h", wb_o.rd_addr,
                            wb_o.rd_wdata, exp_wb.rd_addr, exp_wb.rd_wdata));
        end
        if (exp_wb.csr_we) begin
            assert (wb_o.csr_waddr == exp_wb.csr_waddr && wb_o.csr_wdata == exp_wb.csr_wdata)
                else report_fail($sformatf("csr %h = %h, expected csr %h = %h", wb_o.csr_waddr,
                                 wb_o.csr_wdata, exp_wb.csr_waddr, exp_wb.csr_wdata));
        end
        assert (misalign_o == is_misaligned(exp_ls.mem_op, exp_ls.mem_addr)) else
            report_fail($sformatf("misalign_o %0b for op %0d at %h", misalign_o,
                        exp_ls.mem_op, exp_ls.mem_addr));
    endtask

    // called on a falling edge, returns on the next one.
    task automatic run_cycle(pipe_pkg::ex_ls_t ex, logic [5:0] stall, logic [3:0] flush);
        check_outputs();
        ex_i    = ex;
        stall_i = stall;
        flush_i = flush;
        advance_model(ex, stall, flush);
        @(negedge clk);
    endtask

    initial begin
        int               line;
        int               base;
        int               idle;
        pipe_pkg::ex_ls_t ex;
        clk     = 1'b0;
        reset_i = 1'b1;
        ex_i    = '0;
        stall_i = '0;
        flush_i = '0;
        exp_ls  = '0;
        exp_wb  = '0;
        void'($urandom(32'h7389_4998));
        $readmemh("verif/mem_stage_tests.txt", test_words);
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
        end
        @(negedge clk);
        reset_i = 1'b0;
        line = 0;
        while (line < MAX_LINES && test_words[line * FIELDS] != 32'hff) begin
            base         = line * FIELDS;
            ex.mem_op    = mem_pkg::mem_op_e'(test_words[base][3:0]);
            ex.mem_addr  = test_words[base + 1];
            ex.rd_data   = test_words[base + 3][0] ? $urandom : test_words[base + 2];
            ex.rd_we     = test_words[base + 4][0];
            ex.rd_addr   = test_words[base + 5][4:0];
            ex.csr_we    = test_words[base + 6][0];
            ex.csr_waddr = test_words[base + 7][11:0];
            ex.csr_wdata = test_words[base + 8];
            run_cycle(ex, test_words[base + 9][5:0], test_words[base + 10][3:0]);
            line++;
        end
        if (line == MAX_LINES) begin
            stop_failed("the tests file has no end marker line");
        end
        idle = 0;
        while (exp_ls != '0 || exp_wb != '0) begin
            if (idle == DRAIN_LIMIT) begin
                stop_failed("the pipeline did not drain after the last test line");
            end
            run_cycle('0, '0, '0);
            idle++;
        end
        check_outputs();
        if (line > 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            stop_failed("the tests file holds no test lines");
        end
    end

endmodule

`default_nettype wire

/* verif/mem_stage_tests.txt */
// columns: op addr data rnd rd_we rd csr_we csr_addr csr_data stall flush, hex, one cycle each
// op: 0 none 1 lb 2 lh 3 lw 4 lbu 5 lhu 6 sb 7 sh 8 sw, ff ends the tests; rnd 1 draws data
0 0 0 0 0 0 0 0 0 0 0
8 40 0 1 0 0 0 0 0 0 0
8 44 0 1 0 0 0 0 0 0 0
8 48 a5c3817f 0 0 0 0 0 0 0 0
6 41 90 0 0 0 0 0 0 0 0
7 46 f00d 0 0 0 0 0 0 0 0
3 40 0 0 1 1 0 0 0 0 0
1 41 0 0 1 2 0 0 0 0 0
4 41 0 0 1 3 0 0 0 0 0
2 46 0 0 1 4 0 0 0 0 0
5 46 0 0 1 5 0 0 0 0 0
1 4b 0 0 1 6 0 0 0 0 0
2 4a 0 0 1 7 0 0 0 0 0
3 44 0 0 1 8 0 0 0 0 0
0 0 12345678 0 1 9 0 0 0 0 0
0 0 9abcdef0 0 1 a 1 300 1888 0 0
0 0 0 0 0 0 1 341 80000004 0 0
0 0 0 0 0 0 0 0 0 8 0
8 50 0 1 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 18 0
0 0 0 0 0 0 0 0 0 38 0
3 50 0 0 1 b 0 0 0 0 0
0 0 0 0 0 0 0 0 0 18 0
0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 38 0
8 60 cafef00d 0 0 0 0 0 0 0 0
8 60 deadbeef 0 0 0 0 0 0 0 4
3 60 0 0 1 c 0 0 0 0 0
0 0 55555555 0 1 d 1 305 11 0 0
0 0 0 0 0 0 0 0 0 0 8
7 61 1234 0 0 0 0 0 0 0 0
8 62 ffffffff 0 0 0 0 0 0 0 0
2 63 0 0 1 e 0 0 0 0 0
3 66 0 0 1 f 0 0 0 0 0
3 60 0 0 1 10 0 0 0 0 0
ff 0 0 0 0 0 0 0 0 0 0

/* mem_stage.f */
+incdir+rtl
rtl/mem_pkg.sv
rtl/pipe_pkg.sv
rtl/pipe_reg.sv
rtl/data_ram.sv
rtl/lsu.sv
rtl/mem_stage.sv
verif/mem_stage_sva.sv
verif/mem_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the memory stage testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")"
status=$?
if [ $status -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator is not on the PATH"
    exit 1
fi

verilator --binary --assert --top-module mem_stage_tb -f mem_stage.f \
    -Mdir obj_dir -o mem_stage_tb
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

./obj_dir/mem_stage_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi
exit 0
